/* vlog.f */
logic/calypso_input_pkg.sv
logic/key_event_encoder.sv
logic/mouse_motion_accumulator.sv
logic/event_queue.sv
logic/calypso_input_bridge.sv
verification/calypso_input_checker.sv
verification/calypso_input_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the input bridge testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module calypso_input_tb \
	-f vlog.f \
	-o calypso_input_sim

# a $fatal or a failed assertion gives a non-zero exit status.
./obj_dir/calypso_input_sim

/* verification/calypso_input_tb.sv */
`timescale 1ns/1ps

module calypso_input_tb import calypso_input_pkg::*; ();

	localparam int FIFO_DEPTH  = 16;
	localparam int BUS_TIMEOUT = 20;

	logic      clk_sys;
	logic      rst_n;
	key_in_t   key_in;
	mouse_in_t mouse_in;
	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp;

	logic [15:0]  lfsr_state;
	bit           model_held [512]; // reference copy of the held-key map.
	input_event_t model_q [$];
	logic         model_ovf;
	int           model_dx;
	int           model_dy;
	logic [2:0]   model_btn;
	logic         model_pending;

	calypso_input_bridge #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_dut (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.key_in   (key_in),
		.mouse_in (mouse_in),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int clip_delta(input int v);
		if (v > MOUSE_DELTA_MAX) begin
			return MOUSE_DELTA_MAX;
		end
		if (v < -MOUSE_DELTA_MAX) begin
			return -MOUSE_DELTA_MAX;
		end
		return v;
	endfunction

	function automatic logic [31:0] model_status();
		logic [31:0] s;
		s = '0;
		s[STATUS_COUNT_W-1:0] = 16'(model_q.size());
		s[STATUS_OVF_BIT]     = model_ovf;
		s[STATUS_EMPTY_BIT]   = (model_q.size() == 0);
		return s;
	endfunction

	task automatic end_in_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			end_in_failure();
		end
	endtask

	// the pending motion moves into the queue as soon as there is room.
	task automatic model_take_mouse();
		input_event_t ev;
		if (model_pending && model_q.size() < FIFO_DEPTH) begin
			ev         = '0;
			ev.kind    = EV_MOUSE;
			ev.buttons = model_btn;
			ev.dy      = 8'(model_dy);
			ev.dx      = 8'(model_dx);
			model_q.push_back(ev);
			model_pending = 1'b0;
			model_dx      = 0;
			model_dy      = 0;
			model_btn     = '0;
		end
	endtask

	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdat;
		@(negedge clk_sys);
		while (!wb_rsp.ack) begin
			if (waited == BUS_TIMEOUT) begin
				$display("ERROR: no Wishbone ack within %0d cycles", BUS_TIMEOUT);
				end_in_failure();
			end
			waited++;
			@(negedge clk_sys);
		end
		rdat   = wb_rsp.dat; // data is valid in the ack cycle.
		wb_req = '0;
	endtask

	task automatic verify_status(input string name);
		logic [31:0] got;
		bus_access(1'b0, REG_STATUS, '0, got);
		check_value(name, model_status(), got);
	endtask

	task automatic read_event(input string name);
		logic [31:0] got;
		logic [31:0] expected;
		bus_access(1'b0, REG_EVENT, '0, got);
		expected = '0; // an empty queue reads zero.
		if (model_q.size() > 0) begin
			expected = model_q.pop_front();
		end
		model_take_mouse();
		check_value(name, expected, got);
	endtask

	task automatic drain_queue(input string name);
		while (model_q.size() > 0) begin
			read_event(name);
			verify_status({name, " status after pop"});
		end
		read_event({name, " read of empty queue"});
	endtask

	task automatic key_strobe(input logic pressed, input logic ext, input logic [7:0] code);
		input_event_t ev;
		logic [8:0]   idx;
		idx = {ext, code};
		@(negedge clk_sys);
		key_in = '{strobe: 1'b1, pressed: pressed, extended: ext, code: code};
		@(negedge clk_sys);
		key_in = '0;
		repeat (2) @(negedge clk_sys);
		if (!(pressed && model_held[idx])) begin
			ev          = '0;
			ev.kind     = pressed ? EV_KEY_MAKE : EV_KEY_BREAK;
			ev.extended = ext;
			ev.key_code = code;
			if (model_q.size() < FIFO_DEPTH) begin
				model_q.push_back(ev);
			end else begin
				model_ovf = 1'b1;
			end
		end
		model_held[idx] = pressed;
	endtask

	task automatic mouse_strobe();
		logic signed [8:0] x;
		logic signed [8:0] y;
		logic [7:0]        flags;
		x     = 9'(rand_bits(9));
		y     = 9'(rand_bits(9));
		flags = 8'(rand_bits(8));
		@(negedge clk_sys);
		mouse_in = '{strobe: 1'b1, x: x, y: y, flags: flags};
		@(negedge clk_sys);
		mouse_in = '0;
		repeat (2) @(negedge clk_sys);
		model_dx      = clip_delta(model_dx + int'(x));
		model_dy      = clip_delta(model_dy + int'(y));
		model_btn     = flags[2:0];
		model_pending = 1'b1;
		model_take_mouse();
	endtask

	initial begin
		int          n;
		logic [31:0] rsp_dat;
		key_in        = '0;
		mouse_in      = '0;
		wb_req        = '0;
		rst_n         = 1'b0;
		lfsr_state    = 16'd55;
		model_ovf     = 1'b0;
		model_dx      = 0;
		model_dy      = 0;
		model_btn     = '0;
		model_pending = 1'b0;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		verify_status("status after reset");

		// a small code range makes repeated makes of held keys frequent.
		for (int round = 0; round < 20; round++) begin
			n = 1 + int'(rand_bits(3));
			for (int i = 0; i < n; i++) begin
				key_strobe(1'(rand_bits(1)), 1'(rand_bits(1)), 8'(rand_bits(3)));
				verify_status("status after key push");
			end
			drain_queue("key event");
		end

		for (int round = 0; round < 6; round++) begin
			for (int i = 0; i < 4; i++) begin
				mouse_strobe();
				verify_status("status after mouse push");
			end
			drain_queue("mouse event");
		end

		while (model_q.size() < FIFO_DEPTH) begin
			key_strobe(1'b0, 1'(rand_bits(1)), 8'(rand_bits(8))); // breaks are never filtered.
		end
		verify_status("status with full FIFO");
		for (int i = 0; i < 3; i++) begin
			key_strobe(1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
		end
		verify_status("overflow after lost keys");
		bus_access(1'b1, REG_CTRL, 32'h1 << CTRL_CLR_OVF_BIT, rsp_dat);
		model_ovf = 1'b0;
		verify_status("overflow cleared");

		// motion merges while the FIFO is full and enters after the first pop.
		for (int i = 0; i < 5; i++) begin
			mouse_strobe();
		end
		verify_status("mouse held back while full");
		read_event("first pop of full FIFO");
		verify_status("status after first pop");
		drain_queue("keys then merged mouse");

		for (int i = 0; i < 3; i++) begin
			key_strobe(1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
		end
		verify_status("status before flush");
		bus_access(1'b1, REG_CTRL, 32'h1 << CTRL_FLUSH_BIT, rsp_dat);
		model_q.delete();
		verify_status("status after flush");
		read_event("event read after flush");

		// a full FIFO with overflow set would show a spare write that acts as control.
		while (model_q.size() < FIFO_DEPTH) begin
			key_strobe(1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
		end
		key_strobe(1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
		verify_status("overflow before spare write");
		bus_access(1'b1, 2'd3, 32'hffff_ffff, rsp_dat);
		verify_status("status after spare write");
		bus_access(1'b0, 2'd3, '0, rsp_dat);
		check_value("spare address read", 32'h0, rsp_dat);
		drain_queue("events after spare write");

		$display("All tests passed!");
		$finish;
	end

endmodule

/* verification/calypso_input_checker.sv */
`timescale 1ns/1ps

module calypso_input_checker import calypso_input_pkg::*; #(
	parameter int FIFO_DEPTH = 16,
	parameter int CNT_W      = 5
) (
	input logic             clk_sys,
	input logic             rst_n,
	input wb_req_t          wb_req,
	input wb_rsp_t          wb_rsp,
	input logic [CNT_W-1:0] count
);

	// the ack is registered, so it answers a request of the cycle before.
	ack_needs_request: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
	) else $error("ack raised without cyc and stb");

	single_cycle_ack: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack
	) else $error("ack high on two consecutive cycles");

	count_in_range: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		count <= CNT_W'(FIFO_DEPTH)
	) else $error("queue count above the FIFO depth");

endmodule

bind event_queue calypso_input_checker #(
	.FIFO_DEPTH (FIFO_DEPTH),
	.CNT_W      (CNT_W)
) i_checker (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp),
	.count   (count)
);

/* logic/calypso_input_bridge.sv */
`timescale 1ns/1ps

module calypso_input_bridge import calypso_input_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  key_in_t   key_in,
	input  mouse_in_t mouse_in,
	input  wb_req_t   wb_req,
	output wb_rsp_t   wb_rsp
);

	input_event_t key_event;
	logic         key_valid;
	input_event_t mouse_event;
	logic         mouse_valid;
	logic         mouse_ready;

	key_event_encoder i_key (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.key_in    (key_in),
		.key_event (key_event),
		.key_valid (key_valid)
	);

	// motion is held here while the queue is busy with keys or full.
	mouse_motion_accumulator i_mouse (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.mouse_in    (mouse_in),
		.mouse_ready (mouse_ready),
		.mouse_event (mouse_event),
		.mouse_valid (mouse_valid)
	);

	event_queue #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_queue (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_event   (key_event),
		.key_valid   (key_valid),
		.mouse_event (mouse_event),
		.mouse_valid (mouse_valid),
		.mouse_ready (mouse_ready),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp)
	);

endmodule

/* logic/event_queue.sv */
`timescale 1ns/1ps

module event_queue import calypso_input_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  input_event_t key_event,
	input  logic         key_valid,
	input  input_event_t mouse_event,
	input  logic         mouse_valid,
	output logic         mouse_ready,
	input  wb_req_t      wb_req,
	output wb_rsp_t      wb_rsp
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	input_event_t         fifo_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 overflow;
	logic                 full;
	logic                 empty;

	logic                 busy;
	logic                 bus_req;
	logic                 bus_rd;
	logic                 bus_wr;
	reg_addr_e            reg_addr;
	logic                 ack_q;
	logic [WB_DATA_W-1:0] rsp_dat;
	logic [WB_DATA_W-1:0] rd_data;
	logic [WB_DATA_W-1:0] status_word;

	logic                 pop;
	logic                 flush;
	logic                 clr_ovf;
	logic                 key_push;
	logic                 key_drop;
	logic                 push;
	input_event_t         push_event;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);

	// busy holds off a second ack while the master keeps stb up.
	assign bus_req  = wb_req.cyc && wb_req.stb && !busy;
	assign bus_rd   = bus_req && !wb_req.we;
	assign bus_wr   = bus_req && wb_req.we;
	assign reg_addr = reg_addr_e'(wb_req.adr);

	assign pop     = bus_rd && (reg_addr == REG_EVENT) && !empty;
	assign flush   = bus_wr && (reg_addr == REG_CTRL) && wb_req.dat[CTRL_FLUSH_BIT];
	assign clr_ovf = bus_wr && (reg_addr == REG_CTRL) && wb_req.dat[CTRL_CLR_OVF_BIT];

	// keys win, and the mouse only sees ready when no key is in flight.
	assign mouse_ready = !key_valid && !full;
	assign key_push    = key_valid && (!full || pop);
	assign key_drop    = key_valid && !key_push;
	assign push        = (key_push || (mouse_valid && mouse_ready)) && !flush;
	assign push_event  = key_valid ? key_event : mouse_event;

	always_comb begin
		status_word                   = '0;
		status_word[STATUS_COUNT_W-1:0] = STATUS_COUNT_W'(count);
		status_word[STATUS_OVF_BIT]   = overflow;
		status_word[STATUS_EMPTY_BIT] = empty;
	end

	always_comb begin
		case (reg_addr)
			REG_STATUS: rd_data = status_word;
			REG_EVENT:  rd_data = empty ? '0 : fifo_mem[rd_ptr];
			default:    rd_data = '0; // control and the spare address read zero.
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (push) begin
			fifo_mem[wr_ptr] <= push_event;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			overflow <= 1'b0;
		end else if (key_drop) begin
			overflow <= 1'b1; // a lost key outweighs a clear in the same cycle.
		end else if (clr_ovf) begin
			overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= bus_req;
			if (!(wb_req.cyc && wb_req.stb)) begin
				busy <= 1'b0;
			end else if (bus_req) begin
				busy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (bus_rd) begin
			rsp_dat <= rd_data;
		end else if (bus_wr) begin
			rsp_dat <= '0;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rsp_dat;

endmodule

/* logic/mouse_motion_accumulator.sv */
`timescale 1ns/1ps

module mouse_motion_accumulator import calypso_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  mouse_in_t    mouse_in,
	input  logic         mouse_ready,
	output input_event_t mouse_event,
	output logic         mouse_valid
);

	logic signed [7:0] acc_dx;
	logic signed [7:0] acc_dy;
	logic [2:0]        acc_buttons;
	logic              pending;
	logic              accept;
	logic signed [7:0] base_dx;
	logic signed [7:0] base_dy;

	// adds one raw delta to a running sum and clips it to the symmetric bound.
	function automatic logic signed [7:0] sat_add(
		input logic signed [7:0] acc,
		input logic signed [8:0] delta
	);
		logic signed [9:0] sum;
		sum = {{2{acc[7]}}, acc} + {delta[8], delta};
		if (sum > MOUSE_DELTA_MAX) begin
			return 8'(MOUSE_DELTA_MAX);
		end else if (sum < -MOUSE_DELTA_MAX) begin
			return 8'(-MOUSE_DELTA_MAX);
		end
		return sum[7:0];
	endfunction

	assign accept = pending && mouse_ready;

	// once the pending event is taken, a new strobe starts from zero.
	assign base_dx = accept ? 8'sd0 : acc_dx;
	assign base_dy = accept ? 8'sd0 : acc_dy;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc_dx      <= '0;
			acc_dy      <= '0;
			acc_buttons <= '0;
			pending     <= 1'b0;
		end else if (mouse_in.strobe) begin
			acc_dx      <= sat_add(base_dx, mouse_in.x);
			acc_dy      <= sat_add(base_dy, mouse_in.y); // source sign kept as is.
			acc_buttons <= mouse_in.flags[2:0];
			pending     <= 1'b1;
		end else if (accept) begin
			acc_dx      <= '0;
			acc_dy      <= '0;
			acc_buttons <= '0;
			pending     <= 1'b0;
		end
	end

	always_comb begin
		mouse_event         = '0;
		mouse_event.kind    = EV_MOUSE;
		mouse_event.buttons = acc_buttons;
		mouse_event.dy      = acc_dy;
		mouse_event.dx      = acc_dx;
	end

	assign mouse_valid = pending;

endmodule

/* logic/key_event_encoder.sv */
`timescale 1ns/1ps

module key_event_encoder import calypso_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  key_in_t      key_in,
	output input_event_t key_event,
	output logic         key_valid
);

	logic [511:0] held_map; // one bit per extended and code pair.
	logic [8:0]   key_idx;
	logic         is_held;
	logic         emit;
	input_event_t next_event;

	assign key_idx = {key_in.extended, key_in.code};
	assign is_held = held_map[key_idx];

	// a make of a key that is already down is a typematic repeat and is dropped.
	assign emit = key_in.strobe && (!key_in.pressed || !is_held);

	always_comb begin
		next_event          = '0;
		next_event.kind     = key_in.pressed ? EV_KEY_MAKE : EV_KEY_BREAK;
		next_event.extended = key_in.extended;
		next_event.key_code = key_in.code;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			held_map <= '0;
		end else if (key_in.strobe) begin
			held_map[key_idx] <= key_in.pressed; // a break always releases the key.
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			key_valid <= 1'b0;
		end else begin
			key_valid <= emit; // one cycle pulse, the queue has no way to stall it.
		end
	end

	always_ff @(posedge clk_sys) begin
		if (emit) begin
			key_event <= next_event;
		end
	end

endmodule

/* logic/calypso_input_pkg.sv */
package calypso_input_pkg;

	localparam int WB_ADDR_W = 2;
	localparam int WB_DATA_W = 32;

	// saturation bound of the accumulated mouse delta per axis.
	localparam int MOUSE_DELTA_MAX = 127;

	// status register layout.
	localparam int STATUS_COUNT_W   = 16;
	localparam int STATUS_OVF_BIT   = 16;
	localparam int STATUS_EMPTY_BIT = 17;

	// control register layout.
	localparam int CTRL_CLR_OVF_BIT = 0;
	localparam int CTRL_FLUSH_BIT   = 1;

	typedef enum logic [1:0] {
		EV_NONE      = 2'd0,
		EV_KEY_MAKE  = 2'd1,
		EV_KEY_BREAK = 2'd2,
		EV_MOUSE     = 2'd3
	} event_kind_e;

	typedef enum logic [WB_ADDR_W-1:0] {
		REG_STATUS = 2'd0,
		REG_EVENT  = 2'd1,
		REG_CTRL   = 2'd2
	} reg_addr_e;

	// one queue entry, exactly one bus word wide.
	typedef struct packed {
		event_kind_e        kind;
		logic               extended;
		logic [2:0]         buttons;
		logic [1:0]         reserved;
		logic [7:0]         key_code;
		logic signed [7:0]  dy;
		logic signed [7:0]  dx;
	} input_event_t;

	// same grouping as the ps2_key vector of the core.
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_in_t;

	typedef struct packed {
		logic              strobe;
		logic signed [8:0] x;
		logic signed [8:0] y;
		logic [7:0]        flags;
	} mouse_in_t;

	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                 ack;
		logic [WB_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage
